// File: tb.f
+incdir+include
source/e1AlarmPkg.sv
source/lineAlarmCapture.sv
source/channelAlarmCollect.sv
source/regBank.sv
source/e1AlarmTop.sv
testbench/regBank_asserts.sv
testbench/tbTop.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbTop --Mdir build -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./build/VtbTop 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: include/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errCnt = 0; // compare mismatches
int toCnt  = 0; // ack timeouts

// one handshake, inputs move 1 ns after the edge
task automatic busXfer(input string name, input logic wr,
                       input logic [e1AlarmPkg::ADDR_W-1:0] addr,
                       input logic [e1AlarmPkg::DATA_W-1:0] wdata,
                       output logic [e1AlarmPkg::DATA_W-1:0] rdata);
  int n;
  @(posedge Ck_77);
  #1;
  req.cs    = 1'b1;
  req.wr    = wr;
  req.addr  = addr;
  req.wdata = wdata;
  n = 0;
  while (!rsp.ack && n < 16) // ack due after one edge
  begin
    @(posedge Ck_77);
    #1;
    n++;
  end
  if (!rsp.ack)
  begin
    toCnt++;
    $display("FAILED %s: no ack at addr %0d", name, addr);
  end
  rdata  = rsp.rdata;
  req.cs = 1'b0; // drop inside the ack cycle
endtask

task automatic busWrite(input string name, input logic [e1AlarmPkg::ADDR_W-1:0] addr,
                        input logic [e1AlarmPkg::DATA_W-1:0] data);
  logic [e1AlarmPkg::DATA_W-1:0] unused;
  busXfer(name, 1'b1, addr, data, unused);
endtask

task automatic busRead(input string name, input logic [e1AlarmPkg::ADDR_W-1:0] addr,
                       output logic [e1AlarmPkg::DATA_W-1:0] data);
  busXfer(name, 1'b0, addr, '0, data);
endtask

task automatic checkWord(input string name, input logic [e1AlarmPkg::DATA_W-1:0] exp,
                         input logic [e1AlarmPkg::DATA_W-1:0] act);
  if (act !== exp)
  begin
    errCnt++;
    $display("FAILED %s: expected %h actual %h", name, exp, act);
  end
endtask

task automatic checkCtrl(input string name, input e1AlarmPkg::sideCtrlT exp,
                         input e1AlarmPkg::sideCtrlT act);
  if (act !== exp)
  begin
    errCnt++;
    $display("FAILED %s: expected %b actual %b", name, exp, act);
  end
endtask

task automatic checkVec(input string name, input e1AlarmPkg::chanVecT exp,
                        input e1AlarmPkg::chanVecT act);
  if (act !== exp)
  begin
    errCnt++;
    $display("FAILED %s: expected %h actual %h", name, exp, act);
  end
endtask

`endif

// File: testbench/tbTop.sv
`timescale 1ns/1ps
module tbTop;
  import e1AlarmPkg::*;

  localparam int          HI_W     = CHAN_NUM - DATA_W; // channels in a hi half
  localparam bit          WR       = 1'b1;
  localparam bit          RD       = 1'b0;
  localparam groupReportT IDLE_REP = 7'h78;             // cha 15 with no flags

  typedef struct {
    string             name;
    bit                wr;
    bit                vec;    // lo then hi as one channel vector
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;   // write data or expected word
    chanVecT           expVec;
  } stepT;

  logic                        Ck_77;
  logic                        Rs;
  busReqT                      req;
  busRspT                      rsp;
  logic                        sel;
  chanVecT                     los;
  chanVecT                     tsfA;
  chanVecT                     tsfB;
  groupReportT [GROUP_NUM-1:0] rep;
  sideStatusT                  staA;
  sideStatusT                  staB;
  sideCtrlT                    ctrlA;
  sideCtrlT                    ctrlB;
  stepT                        tbl[$];  // pending bus steps
  chanVecT                     expW;    // model of the recovery sticky bits
  chanVecT                     expR;
  chanVecT                     expL;

  `include "tbChecks.svh"

  e1AlarmTop dut0
  (
    .Ck_77   (Ck_77),
    .Rs      (Rs),
    .req_i   (req),
    .sel_i   (sel),
    .los_i   (los),
    .tsfA_i  (tsfA),
    .tsfB_i  (tsfB),
    .rep_i   (rep),
    .staA_i  (staA),
    .staB_i  (staB),
    .rsp_o   (rsp),
    .ctrlA_o (ctrlA),
    .ctrlB_o (ctrlB)
  );

  bind regBank regBankAsserts regBankAsrt0
  (
    .Ck_77 (Ck_77),
    .Rs    (Rs),
    .req_i (req_i),
    .rsp_i (rsp_o)
  );

  initial
  begin
    Ck_77 = 1'b0;
    forever
      #4 Ck_77 = ~Ck_77; // 8 ns period
  end

  task automatic driveSlot();
    @(posedge Ck_77);
    #1; // inputs move just after the edge
  endtask

  function automatic chanVecT randVec();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[CHAN_NUM-1:0];
  endfunction

  task automatic addWord(input string name, input bit wr, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data);
    tbl.push_back('{name, wr, 1'b0, addr, data, '0});
  endtask

  task automatic addVec(input string name, input logic [ADDR_W-1:0] addr, input chanVecT exp);
    tbl.push_back('{name, RD, 1'b1, addr, '0, exp});
  endtask

  task automatic runTable();
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    foreach (tbl[i])
    begin
      if (tbl[i].wr)
        busWrite(tbl[i].name, tbl[i].addr, tbl[i].data);
      else if (!tbl[i].vec)
      begin
        busRead(tbl[i].name, tbl[i].addr, lo);
        checkWord(tbl[i].name, tbl[i].data, lo);
      end
      else
      begin
        busRead(tbl[i].name, tbl[i].addr, lo);
        busRead(tbl[i].name, tbl[i].addr + ADDR_W'(1), hi); // hi half sits next
        checkVec(tbl[i].name, tbl[i].expVec, {hi[HI_W-1:0], lo});
        checkWord({tbl[i].name, " hi pad"}, '0, hi >> HI_W);
      end
    end
    tbl.delete();
  endtask

  // one flagged report per group and then the same channel back to quiet
  task automatic pulseReports();
    int         cha [GROUP_NUM];
    logic [2:0] flg [GROUP_NUM]; // wFul, rEmp, lck
    driveSlot();
    for (int g = 0; g < GROUP_NUM; g++)
    begin
      cha[g] = $urandom_range(GROUP_CHAN - 1, 0);
      flg[g] = 3'($urandom_range(7, 1));
      rep[g] = {CHA_W'(cha[g]), flg[g]};
      expW[g*GROUP_CHAN+cha[g]] |= flg[g][2]; // global channel index
      expR[g*GROUP_CHAN+cha[g]] |= flg[g][1];
      expL[g*GROUP_CHAN+cha[g]] |= flg[g][0];
    end
    driveSlot();
    for (int g = 0; g < GROUP_NUM; g++)
      rep[g] = {CHA_W'(cha[g]), 3'b000};
    driveSlot();
    for (int g = 0; g < GROUP_NUM; g++)
      rep[g] = IDLE_REP;
  endtask

  // cha 14 and 15 carry all flags and must not land anywhere
  task automatic pulseIgnored();
    for (int c = GROUP_CHAN; c < 2**CHA_W; c++)
    begin
      driveSlot();
      for (int g = 0; g < GROUP_NUM; g++)
        rep[g] = {CHA_W'(c), 3'b111};
    end
    driveSlot();
    for (int g = 0; g < GROUP_NUM; g++)
      rep[g] = IDLE_REP;
  endtask

  initial
  begin
    logic [DATA_W-1:0] cfgWord;
    logic [DATA_W-1:0] ctrlWord;
    logic [DATA_W-1:0] r;
    chanVecT           pat;
    chanVecT           hold;
    sideCtrlT          expA;
    sideCtrlT          expB;
    void'($urandom(32'hfbc2_c056));
    req  = '0;
    sel  = 1'b0;
    los  = '0;
    tsfA = '0;
    tsfB = '0;
    staA = '0;
    staB = '0;
    expW = '0;
    expR = '0;
    expL = '0;
    for (int g = 0; g < GROUP_NUM; g++)
      rep[g] = IDLE_REP;
    Rs = 1'b1;
    repeat (16) @(posedge Ck_77);
    #1;
    Rs = 1'b0;

    checkCtrl("ctrlA after reset", '0, ctrlA);
    checkCtrl("ctrlB after reset", '0, ctrlB);
    cfgWord  = $urandom();
    ctrlWord = $urandom();
    addWord("version", RD, ADDR_VERSION, VERSION_VAL);
    addWord("date", RD, ADDR_DATE, DATE_VAL);
    addWord("slot 15", RD, ADDR_W'(15), '0);
    addWord("version write", WR, ADDR_VERSION, ~VERSION_VAL); // read only
    addWord("version kept", RD, ADDR_VERSION, VERSION_VAL);
    addWord("cfg after reset", RD, ADDR_CFG, '0);
    addWord("cfg write", WR, ADDR_CFG, cfgWord);
    addWord("cfg readback", RD, ADDR_CFG, cfgWord);
    addWord("ctrl write", WR, ADDR_CTRL, ctrlWord);
    addWord("ctrl readback", RD, ADDR_CTRL, ctrlWord & 32'h0000_03ff); // 22 pad bits zero
    runTable();
    expA = ctrlWord[4:0]; // side A lowest
    expB = ctrlWord[9:5];
    checkCtrl("ctrlA field", expA, ctrlA);
    checkCtrl("ctrlB field", expB, ctrlB);

    pat  = randVec();
    hold = '0;
    hold[$urandom_range(CHAN_NUM - 1, 0)] = 1'b1; // standing LOS
    driveSlot();
    los = pat | hold;
    driveSlot();
    los = hold;
    addVec("los pulse", ADDR_LOS_LO, pat | hold);
    addVec("los cleared", ADDR_LOS_LO, hold);
    runTable();
    driveSlot(); // let the last clear reload first
    los = '0;
    addVec("los released", ADDR_LOS_LO, hold);
    addVec("los empty", ADDR_LOS_LO, '0);
    runTable();

    for (int s = 0; s < 2; s++)
    begin
      pat = randVec();
      driveSlot();
      sel  = s[0];
      tsfA = pat;
      tsfB = ~pat; // other side disjoint
      driveSlot();
      tsfA = '0;
      tsfB = '0;
      addVec(s[0] ? "tsf side B" : "tsf side A", ADDR_TSF_LO, s[0] ? ~pat : pat);
      addVec("tsf cleared", ADDR_TSF_LO, '0);
      runTable();
    end

    repeat (4)
      pulseReports();
    pulseIgnored();
    addVec("wFul", ADDR_WFUL_LO, expW);
    addVec("rEmp", ADDR_REMP_LO, expR);
    addVec("lck", ADDR_LCK_LO, expL);
    addVec("wFul cleared", ADDR_WFUL_LO, '0);
    addVec("rEmp cleared", ADDR_REMP_LO, '0);
    addVec("lck cleared", ADDR_LCK_LO, '0);
    runTable();

    r = $urandom();
    driveSlot();
    staA = r[8:0];
    staB = r[17:9];
    driveSlot();
    staA = '0;
    staB = '0;
    addWord("side status", RD, ADDR_STA, {14'b0, r[17:9], r[8:0]}); // B over A
    addWord("side status cleared", RD, ADDR_STA, '0);
    runTable();
    driveSlot(); // last ack cycle reaches the bound checker

    $display("errors %0d, ack timeouts %0d, assertion failures %0d", errCnt, toCnt,
             dut0.regBank0.regBankAsrt0.failCnt);
    if (errCnt == 0 && toCnt == 0 && dut0.regBank0.regBankAsrt0.failCnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: testbench/regBank_asserts.sv
`timescale 1ns/1ps
module regBankAsserts
(
  input logic               Ck_77,
  input logic               Rs,
  input e1AlarmPkg::busReqT req_i,
  input e1AlarmPkg::busRspT rsp_i  // regBank response
);

  int failCnt = 0; // failed assertions so far

  // ack is a single pulse per access
  ackOneCycle: assert property (@(posedge Ck_77) disable iff (Rs)
    rsp_i.ack |=> !rsp_i.ack)
    else
    begin
      $error("ack held longer than one cycle");
      failCnt++;
    end

  ackLowInReset: assert property (@(posedge Ck_77)
    Rs |-> !rsp_i.ack)
    else
    begin
      $error("ack raised while reset is active");
      failCnt++;
    end

  // master keeps the address until it sees ack
  addrHeld: assert property (@(posedge Ck_77) disable iff (Rs)
    (req_i.cs && !rsp_i.ack) |=> $stable(req_i.addr))
    else
    begin
      $error("address changed before ack");
      failCnt++;
    end

endmodule

// File: source/e1AlarmTop.sv
`timescale 1ns/1ps
module e1AlarmTop
(
  input  logic                                                 Ck_77,
  input  logic                                                 Rs,
  input  e1AlarmPkg::busReqT                                   req_i,
  input  logic                                                 sel_i,  // A/B select
  input  e1AlarmPkg::chanVecT                                  los_i,
  input  e1AlarmPkg::chanVecT                                  tsfA_i,
  input  e1AlarmPkg::chanVecT                                  tsfB_i,
  input  e1AlarmPkg::groupReportT [e1AlarmPkg::GROUP_NUM-1:0] rep_i,
  input  e1AlarmPkg::sideStatusT                               staA_i,
  input  e1AlarmPkg::sideStatusT                               staB_i,
  output e1AlarmPkg::busRspT                                   rsp_o,
  output e1AlarmPkg::sideCtrlT                                 ctrlA_o,
  output e1AlarmPkg::sideCtrlT                                 ctrlB_o
);
  import e1AlarmPkg::*;

  chanVecT losSticky;  // line side
  chanVecT tsfSticky;
  chanVecT wFulSticky; // recovery side
  chanVecT rEmpSticky;
  chanVecT lckSticky;
  lineClrT lineClr;
  chanClrT chanClr;

  lineAlarmCapture lineCap0
  (
    .Ck_77       (Ck_77),
    .Rs          (Rs),
    .sel_i       (sel_i),
    .los_i       (los_i),
    .tsfA_i      (tsfA_i),
    .tsfB_i      (tsfB_i),
    .clr_i       (lineClr),
    .losSticky_o (losSticky),
    .tsfSticky_o (tsfSticky)
  );

  channelAlarmCollect chanCol0
  (
    .Ck_77        (Ck_77),
    .Rs           (Rs),
    .rep_i        (rep_i),
    .clr_i        (chanClr),
    .wFulSticky_o (wFulSticky),
    .rEmpSticky_o (rEmpSticky),
    .lckSticky_o  (lckSticky)
  );

  regBank regBank0
  (
    .Ck_77        (Ck_77),
    .Rs           (Rs),
    .req_i        (req_i),
    .staA_i       (staA_i),
    .staB_i       (staB_i),
    .losSticky_i  (losSticky),
    .tsfSticky_i  (tsfSticky),
    .wFulSticky_i (wFulSticky),
    .rEmpSticky_i (rEmpSticky),
    .lckSticky_i  (lckSticky),
    .rsp_o        (rsp_o),
    .ctrlA_o      (ctrlA_o),
    .ctrlB_o      (ctrlB_o),
    .lineClr_o    (lineClr),
    .chanClr_o    (chanClr)
  );

endmodule

// File: source/regBank.sv
`timescale 1ns/1ps
module regBank
(
  input  logic                   Ck_77,
  input  logic                   Rs,
  input  e1AlarmPkg::busReqT     req_i,        // cs held until ack
  input  e1AlarmPkg::sideStatusT staA_i,
  input  e1AlarmPkg::sideStatusT staB_i,
  input  e1AlarmPkg::chanVecT    losSticky_i,
  input  e1AlarmPkg::chanVecT    tsfSticky_i,
  input  e1AlarmPkg::chanVecT    wFulSticky_i,
  input  e1AlarmPkg::chanVecT    rEmpSticky_i,
  input  e1AlarmPkg::chanVecT    lckSticky_i,
  output e1AlarmPkg::busRspT     rsp_o,
  output e1AlarmPkg::sideCtrlT   ctrlA_o,
  output e1AlarmPkg::sideCtrlT   ctrlB_o,
  output e1AlarmPkg::lineClrT    lineClr_o,    // pulse with ack
  output e1AlarmPkg::chanClrT    chanClr_o
);
  import e1AlarmPkg::*;

  logic                              ackQ;
  logic [DATA_W-1:0]                 rdQ;        // read data, loaded on accept
  logic [DATA_W-1:0]                 rdNext;
  logic [DATA_W-1:0]                 cfgQ;       // software scratch word
  ctrlWordU                          ctrlQ;
  ctrlWordU                          wrWord;     // incoming word, field view
  logic [2*$bits(sideStatusT)-1:0]   staLive;
  logic [2*$bits(sideStatusT)-1:0]   staStickyQ; // B over A
  logic                              staClrQ;
  logic                              accept;
  logic                              wrAcc;
  logic                              rdAcc;

  assign accept      = req_i.cs & ~ackQ; // idle and selected
  assign wrAcc       = accept & req_i.wr;
  assign rdAcc       = accept & ~req_i.wr;
  assign wrWord.raw  = req_i.wdata;
  assign staLive     = {staB_i, staA_i};

  always_comb
  begin
    case (req_i.addr)
      ADDR_VERSION: rdNext = VERSION_VAL;
      ADDR_DATE:    rdNext = DATE_VAL;
      ADDR_CFG:     rdNext = cfgQ;
      ADDR_CTRL:    rdNext = ctrlQ.raw;             // pad stays zero
      ADDR_STA:     rdNext = DATA_W'(staStickyQ);
      ADDR_LOS_LO:  rdNext = losSticky_i[DATA_W-1:0];
      ADDR_LOS_HI:  rdNext = DATA_W'(losSticky_i[CHAN_NUM-1:DATA_W]);
      ADDR_TSF_LO:  rdNext = tsfSticky_i[DATA_W-1:0];
      ADDR_TSF_HI:  rdNext = DATA_W'(tsfSticky_i[CHAN_NUM-1:DATA_W]);
      ADDR_WFUL_LO: rdNext = wFulSticky_i[DATA_W-1:0];
      ADDR_WFUL_HI: rdNext = DATA_W'(wFulSticky_i[CHAN_NUM-1:DATA_W]);
      ADDR_REMP_LO: rdNext = rEmpSticky_i[DATA_W-1:0];
      ADDR_REMP_HI: rdNext = DATA_W'(rEmpSticky_i[CHAN_NUM-1:DATA_W]);
      ADDR_LCK_LO:  rdNext = lckSticky_i[DATA_W-1:0];
      ADDR_LCK_HI:  rdNext = DATA_W'(lckSticky_i[CHAN_NUM-1:DATA_W]);
      default:      rdNext = '0;                    // slot 15 unused
    endcase
  end

  always_ff @(posedge Ck_77 or posedge Rs)
  begin
    if (Rs)
    begin
      ackQ       <= 1'b0;
      cfgQ       <= '0;
      ctrlQ.raw  <= '0;       // no injection, no recal
      staStickyQ <= '0;
      staClrQ    <= 1'b0;
      lineClr_o  <= '0;
      chanClr_o  <= '0;
    end
    else
    begin
      ackQ <= accept; // exactly one cycle, ackQ blocks re-accept
      if (wrAcc && req_i.addr == ADDR_CFG)
        cfgQ <= req_i.wdata;
      if (wrAcc && req_i.addr == ADDR_CTRL)
      begin
        ctrlQ.side.a <= wrWord.side.a; // upper bits dropped
        ctrlQ.side.b <= wrWord.side.b;
      end
      if (staClrQ)
        staStickyQ <= staLive;              // reload, standing bits survive
      else
        staStickyQ <= staStickyQ | staLive;
      staClrQ          <= rdAcc && (req_i.addr == ADDR_STA);
      lineClr_o.losLo  <= rdAcc && (req_i.addr == ADDR_LOS_LO);
      lineClr_o.losHi  <= rdAcc && (req_i.addr == ADDR_LOS_HI);
      lineClr_o.tsfLo  <= rdAcc && (req_i.addr == ADDR_TSF_LO);
      lineClr_o.tsfHi  <= rdAcc && (req_i.addr == ADDR_TSF_HI);
      chanClr_o.wFulLo <= rdAcc && (req_i.addr == ADDR_WFUL_LO);
      chanClr_o.wFulHi <= rdAcc && (req_i.addr == ADDR_WFUL_HI);
      chanClr_o.rEmpLo <= rdAcc && (req_i.addr == ADDR_REMP_LO);
      chanClr_o.rEmpHi <= rdAcc && (req_i.addr == ADDR_REMP_HI);
      chanClr_o.lckLo  <= rdAcc && (req_i.addr == ADDR_LCK_LO);
      chanClr_o.lckHi  <= rdAcc && (req_i.addr == ADDR_LCK_HI);
    end
  end

  always_ff @(posedge Ck_77)
  begin
    if (accept)
      rdQ <= rdNext; // sampled before the clear lands
  end

  assign rsp_o   = {ackQ, rdQ};
  assign ctrlA_o = ctrlQ.side.a; // field view of the control word
  assign ctrlB_o = ctrlQ.side.b;

endmodule

// File: source/channelAlarmCollect.sv
`timescale 1ns/1ps
module channelAlarmCollect
(
  input  logic                                                 Ck_77,
  input  logic                                                 Rs,
  input  e1AlarmPkg::groupReportT [e1AlarmPkg::GROUP_NUM-1:0] rep_i, // one per group
  input  e1AlarmPkg::chanClrT                                  clr_i,
  output e1AlarmPkg::chanVecT                                  wFulSticky_o,
  output e1AlarmPkg::chanVecT                                  rEmpSticky_o,
  output e1AlarmPkg::chanVecT                                  lckSticky_o
);
  import e1AlarmPkg::*;

  chanVecT wFulLive; // last reported state per channel
  chanVecT rEmpLive;
  chanVecT lckLive;

  // each group reports one channel per cycle, round robin
  always_ff @(posedge Ck_77 or posedge Rs)
  begin
    if (Rs)
    begin
      wFulLive <= '0;
      rEmpLive <= '0;
      lckLive  <= '0;
    end
    else
    begin
      for (int g = 0; g < GROUP_NUM; g++)
      begin
        for (int c = 0; c < GROUP_CHAN; c++)
        begin
          if (rep_i[g].cha == CHA_W'(c)) // cha 14, 15 hit nothing
          begin
            wFulLive[g*GROUP_CHAN+c] <= rep_i[g].wFul;
            rEmpLive[g*GROUP_CHAN+c] <= rep_i[g].rEmp;
            lckLive[g*GROUP_CHAN+c]  <= rep_i[g].lck;
          end
        end
      end
    end
  end

  always_ff @(posedge Ck_77 or posedge Rs)
  begin
    if (Rs)
    begin
      wFulSticky_o <= '0;
      rEmpSticky_o <= '0;
      lckSticky_o  <= '0;
    end
    else
    begin
      wFulSticky_o <= stickyNext(wFulSticky_o, wFulLive, clr_i.wFulLo, clr_i.wFulHi);
      rEmpSticky_o <= stickyNext(rEmpSticky_o, rEmpLive, clr_i.rEmpLo, clr_i.rEmpHi);
      lckSticky_o  <= stickyNext(lckSticky_o, lckLive, clr_i.lckLo, clr_i.lckHi);
    end
  end

endmodule

// File: source/lineAlarmCapture.sv
`timescale 1ns/1ps
module lineAlarmCapture
(
  input  logic                Ck_77,
  input  logic                Rs,          // async, active high
  input  logic                sel_i,       // 0 side A, 1 side B
  input  e1AlarmPkg::chanVecT los_i,       // LIU loss of signal
  input  e1AlarmPkg::chanVecT tsfA_i,      // TSF toward E1, side A
  input  e1AlarmPkg::chanVecT tsfB_i,      // TSF toward E1, side B
  input  e1AlarmPkg::lineClrT clr_i,       // read-clear strobes
  output e1AlarmPkg::chanVecT losSticky_o,
  output e1AlarmPkg::chanVecT tsfSticky_o
);
  import e1AlarmPkg::*;

  chanVecT tsfSel; // active side only

  assign tsfSel = sel_i ? tsfB_i : tsfA_i;

  always_ff @(posedge Ck_77 or posedge Rs)
  begin
    if (Rs)
    begin
      losSticky_o <= '0;
      tsfSticky_o <= '0;
    end
    else
    begin
      losSticky_o <= stickyNext(losSticky_o, los_i, clr_i.losLo, clr_i.losHi);
      tsfSticky_o <= stickyNext(tsfSticky_o, tsfSel, clr_i.tsfLo, clr_i.tsfHi);
    end
  end

endmodule

// File: source/e1AlarmPkg.sv
package e1AlarmPkg;

  localparam int CHAN_NUM   = 42; // E1 tributaries on the card
  localparam int GROUP_NUM  = 3;  // clock recovery groups
  localparam int GROUP_CHAN = 14; // channels served per group
  localparam int CHA_W      = 4;  // channel field in a group report
  localparam int DATA_W     = 32; // register width
  localparam int ADDR_W     = 4;  // 16 slots, 15 used

  localparam logic [DATA_W-1:0] VERSION_VAL = 32'h0000_0102; // major 01, minor 02
  localparam logic [DATA_W-1:0] DATE_VAL    = 32'h2021_0719;

  localparam logic [ADDR_W-1:0] ADDR_VERSION = 4'd0;  // ro
  localparam logic [ADDR_W-1:0] ADDR_DATE    = 4'd1;  // ro
  localparam logic [ADDR_W-1:0] ADDR_CFG     = 4'd2;  // rw software word
  localparam logic [ADDR_W-1:0] ADDR_CTRL    = 4'd3;  // rw A/B control
  localparam logic [ADDR_W-1:0] ADDR_STA     = 4'd4;  // rc side status
  localparam logic [ADDR_W-1:0] ADDR_LOS_LO  = 4'd5;  // rc LOS 31:0
  localparam logic [ADDR_W-1:0] ADDR_LOS_HI  = 4'd6;  // rc LOS 41:32
  localparam logic [ADDR_W-1:0] ADDR_TSF_LO  = 4'd7;
  localparam logic [ADDR_W-1:0] ADDR_TSF_HI  = 4'd8;
  localparam logic [ADDR_W-1:0] ADDR_WFUL_LO = 4'd9;  // recovery FIFO write full
  localparam logic [ADDR_W-1:0] ADDR_WFUL_HI = 4'd10;
  localparam logic [ADDR_W-1:0] ADDR_REMP_LO = 4'd11; // recovery FIFO read empty
  localparam logic [ADDR_W-1:0] ADDR_REMP_HI = 4'd12;
  localparam logic [ADDR_W-1:0] ADDR_LCK_LO  = 4'd13; // recovery NCO lock
  localparam logic [ADDR_W-1:0] ADDR_LCK_HI  = 4'd14;

  typedef logic [CHAN_NUM-1:0] chanVecT; // one bit per channel

  typedef struct packed {
    logic cal;     // delay line calibrated
    logic errSh;   // sync header error
    logic errMf;   // multiframe header error
    logic loSyn;   // loss of frame sync
    logic loMf;    // loss of multiframe
    logic errCrc;
    logic rLoSyn;  // far end
    logic rLoMf;
    logic rErrCrc;
  } sideStatusT;

  typedef struct packed {
    logic recal;    // restart delay calibration
    logic txErrCrc; // tx error injection
    logic txErrSh;
    logic txErrMf;
    logic rxReSyn;  // force rx resync
  } sideCtrlT;

  typedef union packed {
    logic [DATA_W-1:0] raw; // bus view
    struct packed {
      logic [DATA_W-2*$bits(sideCtrlT)-1:0] pad;
      sideCtrlT b;
      sideCtrlT a;
    } side;                 // hardware view
  } ctrlWordU;

  typedef struct packed {
    logic [CHA_W-1:0] cha; // 0..13 valid
    logic wFul;
    logic rEmp;
    logic lck;
  } groupReportT;

  typedef struct packed {
    logic              cs;
    logic              wr; // 1 write, 0 read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } busReqT;

  typedef struct packed {
    logic              ack;   // one cycle
    logic [DATA_W-1:0] rdata; // valid with ack
  } busRspT;

  typedef struct packed {
    logic losLo;
    logic losHi;
    logic tsfLo;
    logic tsfHi;
  } lineClrT;

  typedef struct packed {
    logic wFulLo;
    logic wFulHi;
    logic rEmpLo;
    logic rEmpHi;
    logic lckLo;
    logic lckHi;
  } chanClrT;

  // sticky update, a cleared half reloads from live so a standing alarm stays visible
  function automatic chanVecT stickyNext(chanVecT old, chanVecT live, logic clrLo,
                                         logic clrHi);
    chanVecT nxt;
    nxt = old | live;
    if (clrLo)
      nxt[DATA_W-1:0] = live[DATA_W-1:0];
    if (clrHi)
      nxt[CHAN_NUM-1:DATA_W] = live[CHAN_NUM-1:DATA_W];
    return nxt;
  endfunction

endpackage
